// File: logic/xbar_pkg.sv
// Bus sizes, slave address map and encodings, imported by every crossbar module.
package xbar_pkg;

    // Bus sizes.
    localparam int ADDR_W    = 32;
    localparam int DATA_W    = 32;
    localparam int NUM_MST   = 2;
    localparam int NUM_SLV   = 3;
    localparam int MST_IDX_W = $clog2(NUM_MST);
    localparam int SLV_IDX_W = $clog2(NUM_SLV);

    // Each slave owns a 64 KiB window. Slave 0 is the rightmost entry of each table.
    localparam logic [NUM_SLV-1:0][ADDR_W-1:0] SLV_BASE = {
        32'h43C2_0000,
        32'h43C1_0000,
        32'h43C0_0000
    };

    localparam logic [NUM_SLV-1:0][ADDR_W-1:0] SLV_LAST = {
        32'h43C2_FFFF,
        32'h43C1_FFFF,
        32'h43C0_FFFF
    };

    // AXI response codes used by the crossbar.
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_DECERR = 2'b11
    } resp_e;

    // Read transaction states.
    typedef enum logic [1:0] {
        RD_IDLE = 2'b00,
        RD_ADDR = 2'b01,
        RD_DATA = 2'b10
    } rd_state_e;

endpackage

// File: logic/xbar_rr_arbiter.sv
// Round-robin arbiter that grants the read path to one master and holds it until ack.
`timescale 1ns/1ps

module xbar_rr_arbiter
    import xbar_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  logic [NUM_MST-1:0]   req_i,
    input  logic                 ack_i,
    output logic                 grant_valid_o,
    output logic [MST_IDX_W-1:0] grant_idx_o
);

    logic [MST_IDX_W-1:0] last_q;
    logic [MST_IDX_W-1:0] held_q;
    logic                 lock_q;
    logic                 pick_valid;
    logic [MST_IDX_W-1:0] pick_idx;

    // Search starts at the master after the last one served.
    always_comb begin
        int cand;
        pick_valid = 1'b0;
        pick_idx   = '0;
        cand       = 0;
        for (int off = 1; off <= NUM_MST; off++) begin
            cand = (int'(last_q) + off) % NUM_MST;
            if (!pick_valid && req_i[cand]) begin
                pick_valid = 1'b1;
                pick_idx   = MST_IDX_W'(cand);
            end
        end
    end

    // No new grant is offered while a transaction still owns the read path.
    assign grant_valid_o = pick_valid && !lock_q;
    assign grant_idx_o   = lock_q ? held_q : pick_idx;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            lock_q <= 1'b0;
            held_q <= '0;
            last_q <= MST_IDX_W'(NUM_MST - 1);
        end else if (ack_i) begin
            lock_q <= 1'b0;
            last_q <= held_q;
        end else if (grant_valid_o) begin
            lock_q <= 1'b1;
            held_q <= pick_idx;
        end
    end

    // The state machine only ever acknowledges a transaction that was granted earlier.
    a_ack_after_grant: assert property (@(posedge clk_i) disable iff (!rstn_i)
        ack_i |-> lock_q)
        else $error("ack seen without a prior grant");

endmodule

// File: logic/xbar_addr_decoder.sv
// Address decoder that maps a read address to a slave index and a hit flag.
`timescale 1ns/1ps

module xbar_addr_decoder
    import xbar_pkg::*;
(
    input  logic [ADDR_W-1:0]    addr_i,
    output logic                 hit_o,
    output logic [SLV_IDX_W-1:0] slv_idx_o
);

    // Windows are scanned from slave 0 upward, so the lowest match wins on overlap.
    always_comb begin
        hit_o     = 1'b0;
        slv_idx_o = '0;
        for (int i = 0; i < NUM_SLV; i++) begin
            if (!hit_o && (addr_i >= SLV_BASE[i]) && (addr_i <= SLV_LAST[i])) begin
                hit_o     = 1'b1;
                slv_idx_o = SLV_IDX_W'(i);
            end
        end
    end

endmodule

// File: logic/xbar_rd_fsm.sv
// Read transaction FSM that latches the granted master and its target slave for the router.
`timescale 1ns/1ps

module xbar_rd_fsm
    import xbar_pkg::*;
(
    input  logic                           clk_i,
    input  logic                           rstn_i,
    input  logic [NUM_MST-1:0][ADDR_W-1:0] s_araddr_i,
    input  logic                           grant_valid_i,
    input  logic [MST_IDX_W-1:0]           grant_idx_i,
    input  logic                           ar_done_i,
    input  logic                           r_done_i,
    output rd_state_e                      state_o,
    output logic [MST_IDX_W-1:0]           sel_mst_o,
    output logic [SLV_IDX_W-1:0]           sel_slv_o,
    output logic                           sel_hit_o,
    output logic                           ack_o
);

    rd_state_e            state_q;
    rd_state_e            state_d;
    logic [MST_IDX_W-1:0] sel_mst_q;
    logic [SLV_IDX_W-1:0] sel_slv_q;
    logic                 sel_hit_q;
    logic                 dec_hit;
    logic [SLV_IDX_W-1:0] dec_slv;

    // The granted master's address is decoded while the FSM is still idle.
    xbar_addr_decoder i_addr_decoder (
        .addr_i    (s_araddr_i[grant_idx_i]),
        .hit_o     (dec_hit),
        .slv_idx_o (dec_slv)
    );

    always_comb begin
        state_d = state_q;
        case (state_q)
            RD_IDLE: begin
                if (grant_valid_i) begin
                    state_d = RD_ADDR;
                end
            end
            RD_ADDR: begin
                if (ar_done_i) begin
                    state_d = RD_DATA;
                end
            end
            RD_DATA: begin
                if (r_done_i) begin
                    state_d = RD_IDLE;
                end
            end
            default: state_d = RD_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q   <= RD_IDLE;
            sel_mst_q <= '0;
            sel_slv_q <= '0;
            sel_hit_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if ((state_q == RD_IDLE) && grant_valid_i) begin
                sel_mst_q <= grant_idx_i;
                sel_slv_q <= dec_slv;
                sel_hit_q <= dec_hit;
            end
        end
    end

    assign state_o   = state_q;
    assign sel_mst_o = sel_mst_q;
    assign sel_slv_o = sel_slv_q;
    assign sel_hit_o = sel_hit_q;

    // Releases the arbiter on the final R transfer.
    assign ack_o = (state_q == RD_DATA) && r_done_i;

    // The owning master stays the one the arbiter holds for the whole transaction.
    a_sel_mst_stable: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (state_q != RD_IDLE) |-> (sel_mst_q == grant_idx_i))
        else $error("selected master differs from the granted master during a transaction");

endmodule

// File: logic/xbar_rd_router.sv
// Combinational router for the AR and R channels between the owning master and its slave.
`timescale 1ns/1ps

module xbar_rd_router
    import xbar_pkg::*;
(
    input  rd_state_e                      state_i,
    input  logic [MST_IDX_W-1:0]           sel_mst_i,
    input  logic [SLV_IDX_W-1:0]           sel_slv_i,
    input  logic                           sel_hit_i,
    input  logic [NUM_MST-1:0][ADDR_W-1:0] s_araddr_i,
    input  logic [NUM_MST-1:0]             s_arvalid_i,
    output logic [NUM_MST-1:0]             s_arready_o,
    output logic [NUM_MST-1:0][DATA_W-1:0] s_rdata_o,
    output resp_e [NUM_MST-1:0]            s_rresp_o,
    output logic [NUM_MST-1:0]             s_rvalid_o,
    input  logic [NUM_MST-1:0]             s_rready_i,
    output logic [NUM_SLV-1:0][ADDR_W-1:0] m_araddr_o,
    output logic [NUM_SLV-1:0]             m_arvalid_o,
    input  logic [NUM_SLV-1:0]             m_arready_i,
    input  logic [NUM_SLV-1:0][DATA_W-1:0] m_rdata_i,
    input  logic [NUM_SLV-1:0][1:0]        m_rresp_i,
    input  logic [NUM_SLV-1:0]             m_rvalid_i,
    output logic [NUM_SLV-1:0]             m_rready_o,
    output logic                           ar_done_o,
    output logic                           r_done_o
);

    // Only the decoded target slave ever sees activity, and a miss reaches no slave.
    always_comb begin
        m_araddr_o  = '0;
        m_arvalid_o = '0;
        m_rready_o  = '0;
        if (sel_hit_i) begin
            case (state_i)
                RD_ADDR: begin
                    m_araddr_o[sel_slv_i]  = s_araddr_i[sel_mst_i];
                    m_arvalid_o[sel_slv_i] = s_arvalid_i[sel_mst_i];
                end
                RD_DATA: begin
                    m_rready_o[sel_slv_i] = s_rready_i[sel_mst_i];
                end
                default: ;
            endcase
        end
    end

    // A miss is answered here with DECERR and zero data.
    always_comb begin
        s_arready_o = '0;
        s_rvalid_o  = '0;
        s_rdata_o   = '0;
        for (int i = 0; i < NUM_MST; i++) begin
            s_rresp_o[i] = RESP_OKAY;
        end
        case (state_i)
            RD_ADDR: begin
                s_arready_o[sel_mst_i] = sel_hit_i ? m_arready_i[sel_slv_i] : 1'b1;
            end
            RD_DATA: begin
                if (sel_hit_i) begin
                    s_rvalid_o[sel_mst_i] = m_rvalid_i[sel_slv_i];
                    s_rdata_o[sel_mst_i]  = m_rdata_i[sel_slv_i];
                    s_rresp_o[sel_mst_i]  = resp_e'(m_rresp_i[sel_slv_i]);
                end else begin
                    s_rvalid_o[sel_mst_i] = 1'b1;
                    s_rresp_o[sel_mst_i]  = RESP_DECERR;
                end
            end
            default: ;
        endcase
    end

    // Handshakes are observed on the master side so hits and misses look alike.
    assign ar_done_o = (state_i == RD_ADDR) && s_arvalid_i[sel_mst_i] && s_arready_o[sel_mst_i];
    assign r_done_o  = (state_i == RD_DATA) && s_rvalid_o[sel_mst_i] && s_rready_i[sel_mst_i];

    // A hit always names an existing slave, so arvalid reaches exactly one slave.
    always_comb begin
        a_one_target: assert final (!sel_hit_i || (sel_slv_i < SLV_IDX_W'(NUM_SLV)))
            else $error("a hit selects a slave outside the address map");
    end

endmodule

// File: logic/axil_rd_xbar.sv
// Top level of the two-master, three-slave AXI4-Lite read crossbar.
`timescale 1ns/1ps

module axil_rd_xbar
    import xbar_pkg::*;
(
    input  logic                           clk_i,
    input  logic                           rstn_i,
    // Master side.
    input  logic [NUM_MST-1:0][ADDR_W-1:0] s_araddr_i,
    input  logic [NUM_MST-1:0]             s_arvalid_i,
    output logic [NUM_MST-1:0]             s_arready_o,
    output logic [NUM_MST-1:0][DATA_W-1:0] s_rdata_o,
    output resp_e [NUM_MST-1:0]            s_rresp_o,
    output logic [NUM_MST-1:0]             s_rvalid_o,
    input  logic [NUM_MST-1:0]             s_rready_i,
    // Slave side.
    output logic [NUM_SLV-1:0][ADDR_W-1:0] m_araddr_o,
    output logic [NUM_SLV-1:0]             m_arvalid_o,
    input  logic [NUM_SLV-1:0]             m_arready_i,
    input  logic [NUM_SLV-1:0][DATA_W-1:0] m_rdata_i,
    input  logic [NUM_SLV-1:0][1:0]        m_rresp_i,
    input  logic [NUM_SLV-1:0]             m_rvalid_i,
    output logic [NUM_SLV-1:0]             m_rready_o
);

    logic                 grant_valid;
    logic [MST_IDX_W-1:0] grant_idx;
    rd_state_e            state;
    logic [MST_IDX_W-1:0] sel_mst;
    logic [SLV_IDX_W-1:0] sel_slv;
    logic                 sel_hit;
    logic                 ar_done;
    logic                 r_done;
    logic                 ack;

    xbar_rr_arbiter i_rr_arbiter (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .req_i         (s_arvalid_i),
        .ack_i         (ack),
        .grant_valid_o (grant_valid),
        .grant_idx_o   (grant_idx)
    );

    xbar_rd_fsm i_rd_fsm (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .s_araddr_i    (s_araddr_i),
        .grant_valid_i (grant_valid),
        .grant_idx_i   (grant_idx),
        .ar_done_i     (ar_done),
        .r_done_i      (r_done),
        .state_o       (state),
        .sel_mst_o     (sel_mst),
        .sel_slv_o     (sel_slv),
        .sel_hit_o     (sel_hit),
        .ack_o         (ack)
    );

    xbar_rd_router i_rd_router (
        .state_i     (state),
        .sel_mst_i   (sel_mst),
        .sel_slv_i   (sel_slv),
        .sel_hit_i   (sel_hit),
        .s_araddr_i  (s_araddr_i),
        .s_arvalid_i (s_arvalid_i),
        .s_arready_o (s_arready_o),
        .s_rdata_o   (s_rdata_o),
        .s_rresp_o   (s_rresp_o),
        .s_rvalid_o  (s_rvalid_o),
        .s_rready_i  (s_rready_i),
        .m_araddr_o  (m_araddr_o),
        .m_arvalid_o (m_arvalid_o),
        .m_arready_i (m_arready_i),
        .m_rdata_i   (m_rdata_i),
        .m_rresp_i   (m_rresp_i),
        .m_rvalid_i  (m_rvalid_i),
        .m_rready_o  (m_rready_o),
        .ar_done_o   (ar_done),
        .r_done_o    (r_done)
    );

endmodule

// File: dv/xbar_slave_model.sv
// Behavioral AXI4-Lite read slave for the testbench, answering with random ready and valid delays.
`timescale 1ns/1ps

module xbar_slave_model
    import xbar_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  logic [SLV_IDX_W-1:0] slv_idx_i,
    input  logic [ADDR_W-1:0]    araddr_i,
    input  logic                 arvalid_i,
    output logic                 arready_o,
    output logic [DATA_W-1:0]    rdata_o,
    output logic [1:0]           rresp_o,
    output logic                 rvalid_o,
    input  logic                 rready_i
);

    localparam int DRIVE_DLY   = 1;
    localparam int RREADY_WAIT = 200;

    // Each slave uses its own key, so a read routed to the wrong slave returns wrong data.
    function automatic logic [DATA_W-1:0] data_key(input logic [SLV_IDX_W-1:0] idx);
        case (idx)
            2'd0:    return 32'h1111_0000;
            2'd1:    return 32'h2222_0000;
            default: return 32'h3333_0000;
        endcase
    endfunction

    initial begin
        logic [ADDR_W-1:0] addr;
        int unsigned       delay;
        int                waited;
        arready_o = 1'b0;
        rvalid_o  = 1'b0;
        rdata_o   = '0;
        rresp_o   = 2'b00;
        forever begin
            @(negedge clk_i);
            if (rstn_i && arvalid_i) begin
                // The address is held by the source until the AR transfer.
                addr  = araddr_i;
                delay = $urandom % 4;
                repeat (delay) @(posedge clk_i);
                @(posedge clk_i);
                #(DRIVE_DLY);
                arready_o = 1'b1;
                @(posedge clk_i);
                #(DRIVE_DLY);
                arready_o = 1'b0;
                delay = $urandom % 4;
                if (delay != 0) begin
                    repeat (delay) @(posedge clk_i);
                    #(DRIVE_DLY);
                end
                rdata_o  = addr ^ data_key(slv_idx_i);
                rresp_o  = RESP_OKAY;
                rvalid_o = 1'b1;
                waited   = 0;
                do begin
                    @(negedge clk_i);
                    waited++;
                end while (!rready_i && (waited < RREADY_WAIT));
                if (!rready_i) begin
                    $display("Slave %0d gave up waiting for rready at %0t", slv_idx_i, $time);
                end
                @(posedge clk_i);
                #(DRIVE_DLY);
                rvalid_o = 1'b0;
                rdata_o  = '0;
            end
        end
    end

endmodule

// File: dv/tb_axil_rd_xbar.sv
// Testbench for the AXI4-Lite read crossbar, driving both masters from a table of reads.
`timescale 1ns/1ps

module tb_axil_rd_xbar
    import xbar_pkg::*;
();

    localparam int          CLK_HALF   = 50;
    localparam int          DRIVE_DLY  = 1;
    localparam int          RESET_CYC  = 16;
    localparam int          WAIT_LIMIT = 200;
    localparam logic [31:0] SEED       = 32'hbf38_b10c;
    localparam int          N_VEC      = 13;

    // Burst entries run from both masters at once, with random rready stalls.
    typedef struct packed {
        int                 mst;
        logic [ADDR_W-1:0]  addr;
        int                 stall;
        logic               burst;
        resp_e              exp_resp;
        logic [DATA_W-1:0]  exp_data;
        logic [NUM_SLV-1:0] exp_seen;
    } read_vec_t;

    logic                           clk;
    logic                           rstn;
    logic [NUM_MST-1:0][ADDR_W-1:0] s_araddr;
    logic [NUM_MST-1:0]             s_arvalid;
    logic [NUM_MST-1:0]             s_arready;
    logic [NUM_MST-1:0][DATA_W-1:0] s_rdata;
    resp_e [NUM_MST-1:0]            s_rresp;
    logic [NUM_MST-1:0]             s_rvalid;
    logic [NUM_MST-1:0]             s_rready;
    logic [NUM_SLV-1:0][ADDR_W-1:0] m_araddr;
    logic [NUM_SLV-1:0]             m_arvalid;
    logic [NUM_SLV-1:0]             m_arready;
    logic [NUM_SLV-1:0][DATA_W-1:0] m_rdata;
    logic [NUM_SLV-1:0][1:0]        m_rresp;
    logic [NUM_SLV-1:0]             m_rvalid;
    logic [NUM_SLV-1:0]             m_rready;

    read_vec_t          vecs [N_VEC];
    logic [NUM_SLV-1:0] arvalid_seen;
    int                 done_order [$];
    int                 n_checks;
    int                 n_errors;

    axil_rd_xbar i_axil_rd_xbar (
        .clk_i       (clk),
        .rstn_i      (rstn),
        .s_araddr_i  (s_araddr),
        .s_arvalid_i (s_arvalid),
        .s_arready_o (s_arready),
        .s_rdata_o   (s_rdata),
        .s_rresp_o   (s_rresp),
        .s_rvalid_o  (s_rvalid),
        .s_rready_i  (s_rready),
        .m_araddr_o  (m_araddr),
        .m_arvalid_o (m_arvalid),
        .m_arready_i (m_arready),
        .m_rdata_i   (m_rdata),
        .m_rresp_i   (m_rresp),
        .m_rvalid_i  (m_rvalid),
        .m_rready_o  (m_rready)
    );

    for (genvar g = 0; g < NUM_SLV; g++) begin : g_slave
        xbar_slave_model i_slave_model (
            .clk_i     (clk),
            .rstn_i    (rstn),
            .slv_idx_i (SLV_IDX_W'(g)),
            .araddr_i  (m_araddr[g]),
            .arvalid_i (m_arvalid[g]),
            .arready_o (m_arready[g]),
            .rdata_o   (m_rdata[g]),
            .rresp_o   (m_rresp[g]),
            .rvalid_o  (m_rvalid[g]),
            .rready_i  (m_rready[g])
        );
    end

    initial clk = 1'b0;
    always #(CLK_HALF) clk = ~clk;

    // Records every slave that sees arvalid during the current test.
    always @(negedge clk) begin
        arvalid_seen = arvalid_seen | m_arvalid;
    end

    // Expected data is the address XOR the slave key: 1111_0000, 2222_0000, 3333_0000.
    task automatic load_table();
        vecs[0]  = '{0, 32'h43C0_0010, 0, 1'b0, RESP_OKAY,   32'h52D1_0010, 3'b001};
        vecs[1]  = '{1, 32'h43C1_0020, 0, 1'b0, RESP_OKAY,   32'h61E3_0020, 3'b010};
        vecs[2]  = '{0, 32'h43C2_FFFC, 0, 1'b0, RESP_OKAY,   32'h70F1_FFFC, 3'b100};
        vecs[3]  = '{1, 32'h43C3_0000, 0, 1'b0, RESP_DECERR, 32'h0000_0000, 3'b000};
        vecs[4]  = '{0, 32'h1000_0000, 2, 1'b0, RESP_DECERR, 32'h0000_0000, 3'b000};
        vecs[5]  = '{1, 32'h43C0_FFF0, 5, 1'b0, RESP_OKAY,   32'h52D1_FFF0, 3'b001};
        vecs[6]  = '{0, 32'h43C1_0100, 3, 1'b0, RESP_OKAY,   32'h61E3_0100, 3'b010};
        vecs[7]  = '{0, 32'h43C2_0004, 0, 1'b1, RESP_OKAY,   32'h70F1_0004, 3'b100};
        vecs[8]  = '{1, 32'h43C0_0008, 0, 1'b1, RESP_OKAY,   32'h52D1_0008, 3'b001};
        vecs[9]  = '{0, 32'h43C1_000C, 0, 1'b1, RESP_OKAY,   32'h61E3_000C, 3'b010};
        vecs[10] = '{1, 32'h43C2_0010, 0, 1'b1, RESP_OKAY,   32'h70F1_0010, 3'b100};
        vecs[11] = '{0, 32'h43BF_FFFC, 0, 1'b1, RESP_DECERR, 32'h0000_0000, 3'b000};
        vecs[12] = '{1, 32'h43C1_0014, 0, 1'b1, RESP_OKAY,   32'h61E3_0014, 3'b010};
    endtask

    task automatic check_eq(input string what, input logic [31:0] got,
                            input logic [31:0] exp, inout int test_errs);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            test_errs++;
            $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("Timed out at %0t waiting for %s", $time, what);
        $display("Test failed");
        $finish;
    endtask

    task automatic report_test(input string name, input int test_errs);
        $display("%s: %s", name, (test_errs == 0) ? "ok" : "error");
    endtask

    // One complete read from master m, with rready held low for stall cycles.
    // It starts a small delay after a rising edge and returns at the same point
    // after the R transfer, so the master can request again right away.
    task automatic read_once(input int m, input logic [ADDR_W-1:0] addr, input int stall,
                             input logic [NUM_SLV-1:0] exp_slv,
                             output resp_e got_resp, output logic [DATA_W-1:0] got_data,
                             inout int test_errs);
        int waited;
        s_araddr[m]  = addr;
        s_arvalid[m] = 1'b1;
        waited       = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) fail_timeout($sformatf("arready of master %0d", m));
        end while (!s_arready[m]);
        @(posedge clk);
        #(DRIVE_DLY);
        s_arvalid[m] = 1'b0;
        waited       = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) fail_timeout($sformatf("rvalid of master %0d", m));
        end while (!s_rvalid[m]);
        got_resp = s_rresp[m];
        got_data = s_rdata[m];
        repeat (stall) begin
            @(negedge clk);
            check_eq("rvalid during stall", s_rvalid[m], 1, test_errs);
            check_eq("rresp during stall", s_rresp[m], got_resp, test_errs);
            check_eq("rdata during stall", s_rdata[m], got_data, test_errs);
        end
        @(posedge clk);
        #(DRIVE_DLY);
        s_rready[m] = 1'b1;
        @(negedge clk);
        check_eq("rvalid at transfer", s_rvalid[m], 1, test_errs);
        check_eq("rdata at transfer", s_rdata[m], got_data, test_errs);
        check_eq("m_rready at transfer", m_rready, exp_slv, test_errs);
        @(posedge clk);
        done_order.push_back(m);
        #(DRIVE_DLY);
        s_rready[m] = 1'b0;
    endtask

    task automatic run_stream(input int m);
        resp_e             got_resp;
        logic [DATA_W-1:0] got_data;
        int                test_errs;
        for (int i = 0; i < N_VEC; i++) begin
            if (vecs[i].burst && (vecs[i].mst == m)) begin
                test_errs = 0;
                read_once(m, vecs[i].addr, int'($urandom % 4), vecs[i].exp_seen,
                          got_resp, got_data, test_errs);
                check_eq("rresp", got_resp, vecs[i].exp_resp, test_errs);
                check_eq("rdata", got_data, vecs[i].exp_data, test_errs);
                report_test($sformatf("test %0d master %0d addr %h", i, m, vecs[i].addr),
                            test_errs);
            end
        end
    endtask

    initial begin
        resp_e             got_resp;
        logic [DATA_W-1:0] got_data;
        int                test_errs;
        int                last_seq;
        int                n_burst;
        void'($urandom(SEED));
        n_checks     = 0;
        n_errors     = 0;
        arvalid_seen = '0;
        rstn         = 1'b0;
        s_araddr     = '0;
        s_arvalid    = '0;
        s_rready     = '0;
        load_table();
        repeat (RESET_CYC) @(posedge clk);
        #(DRIVE_DLY);
        rstn = 1'b1;

        test_errs = 0;
        @(negedge clk);
        check_eq("s_arready after reset", s_arready, 0, test_errs);
        check_eq("s_rvalid after reset", s_rvalid, 0, test_errs);
        check_eq("m_arvalid after reset", m_arvalid, 0, test_errs);
        check_eq("m_rready after reset", m_rready, 0, test_errs);
        report_test("test reset", test_errs);

        // Reads start a small delay after a rising edge.
        @(posedge clk);
        #(DRIVE_DLY);

        last_seq = 0;
        n_burst  = 0;
        for (int i = 0; i < N_VEC; i++) begin
            if (vecs[i].burst) begin
                n_burst++;
            end else begin
                test_errs    = 0;
                arvalid_seen = '0;
                read_once(vecs[i].mst, vecs[i].addr, vecs[i].stall, vecs[i].exp_seen,
                          got_resp, got_data, test_errs);
                check_eq("rresp", got_resp, vecs[i].exp_resp, test_errs);
                check_eq("rdata", got_data, vecs[i].exp_data, test_errs);
                check_eq("slaves seeing arvalid", arvalid_seen, vecs[i].exp_seen, test_errs);
                report_test($sformatf("test %0d master %0d addr %h", i, vecs[i].mst,
                                      vecs[i].addr), test_errs);
                last_seq = vecs[i].mst;
            end
        end

        // The master after the last one served wins first, then grants alternate.
        done_order.delete();
        fork
            run_stream(0);
            run_stream(1);
        join
        test_errs = 0;
        check_eq("completions", done_order.size(), n_burst, test_errs);
        for (int i = 0; i < done_order.size(); i++) begin
            check_eq("completion order", done_order[i], (last_seq + 1 + i) % NUM_MST,
                     test_errs);
        end
        report_test("test round-robin order", test_errs);

        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: axil_rd_xbar.f
logic/xbar_pkg.sv
logic/xbar_rr_arbiter.sv
logic/xbar_addr_decoder.sv
logic/xbar_rd_fsm.sv
logic/xbar_rd_router.sv
logic/axil_rd_xbar.sv
dv/xbar_slave_model.sv
dv/tb_axil_rd_xbar.sv

// File: Bender.yml
package:
  name: axil_rd_xbar

sources:
  - files:
      - logic/xbar_pkg.sv
      - logic/xbar_rr_arbiter.sv
      - logic/xbar_addr_decoder.sv
      - logic/xbar_rd_fsm.sv
      - logic/xbar_rd_router.sv
      - logic/axil_rd_xbar.sv
  - target: test
    files:
      - dv/xbar_slave_model.sv
      - dv/tb_axil_rd_xbar.sv
